/* files.f */
hw/trap_pkg.sv
hw/intr_sync.sv
hw/trap_arbiter.sv
hw/csr_regs.sv
hw/pc_redirect.sv
hw/trap_ctrl_top.sv
tests/tb_trap_ctrl.sv

/* hw/csr_regs.sv */
module csr_regs (
        input  logic                clk,
        input  logic                clrn,
        input  trap_pkg::apb_req_t  apb_req,
        output trap_pkg::apb_rsp_t  apb_rsp,
        input  logic                pending,          // from intr_sync, shown as mip.meip
        input  trap_pkg::trap_req_t taken,            // trap entry this cycle
        input  logic                mret_commit,      // mret leaving wb
        output logic                intr_req,         // to arbiter
        output trap_pkg::xlen_t     mtvec,
        output trap_pkg::xlen_t     mepc
);

        trap_pkg::xlen_t mstatus;
        trap_pkg::xlen_t mie;
        trap_pkg::xlen_t mip;                           // read-only view
        trap_pkg::xlen_t mcause;
        trap_pkg::xlen_t mcause_nxt;                    // value written on trap entry
        trap_pkg::xlen_t rdata;                         // read mux out
        logic            hit;                           // offset is mapped
        logic            access;                        // apb access phase
        logic            wr;                            // apb write this edge

        assign access = apb_req.psel & apb_req.penable;
        assign wr     = access & apb_req.pwrite;

        always_comb begin
                mip                     = '0;
                mip[trap_pkg::MIP_MEIP] = pending;
        end

        always_comb begin
                mcause_nxt                              = '0;
                mcause_nxt[trap_pkg::CAUSE_W-1:0]       = taken.cause;
                mcause_nxt[trap_pkg::MCAUSE_INTR_BIT]   = taken.is_intr;
        end

        // read decode
        always_comb begin
                rdata = '0;
                hit   = 1'b1;
                case (apb_req.paddr)
                        trap_pkg::ADDR_MSTATUS: rdata = mstatus;
                        trap_pkg::ADDR_MIE:     rdata = mie;
                        trap_pkg::ADDR_MIP:     rdata = mip;
                        trap_pkg::ADDR_MEPC:    rdata = mepc;
                        trap_pkg::ADDR_MCAUSE:  rdata = mcause;
                        trap_pkg::ADDR_MTVEC:   rdata = mtvec;
                        default:                hit   = 1'b0;   // unmapped offset
                endcase
        end

        assign apb_rsp.prdata  = (access & ~apb_req.pwrite) ? rdata : '0;
        assign apb_rsp.pready  = 1'b1;                  // no wait states
        assign apb_rsp.pslverr = access & ~hit;

        // apb first, trap and mret later so they win the same bits
        always_ff @(posedge clk or negedge clrn) begin
                if (!clrn) begin
                        mstatus <= '0;
                        mie     <= '0;
                        mepc    <= '0;
                        mcause  <= '0;
                        mtvec   <= trap_pkg::MTVEC_RESET;
                end else begin
                        if (wr) begin
                                case (apb_req.paddr)
                                        trap_pkg::ADDR_MSTATUS: mstatus <= apb_req.pwdata;
                                        trap_pkg::ADDR_MIE:     mie     <= apb_req.pwdata;
                                        trap_pkg::ADDR_MEPC:    mepc    <= apb_req.pwdata;
                                        trap_pkg::ADDR_MCAUSE:  mcause  <= apb_req.pwdata;
                                        trap_pkg::ADDR_MTVEC:   mtvec   <= apb_req.pwdata;
                                        default: ;      // mip and holes ignore writes
                                endcase
                        end
                        if (taken.valid) begin
                                mepc   <= taken.pc;
                                mcause <= mcause_nxt;
                                mstatus[trap_pkg::MSTATUS_MPIE] <= mstatus[trap_pkg::MSTATUS_MIE];
                                mstatus[trap_pkg::MSTATUS_MIE]  <= 1'b0;    // mask nested ints
                        end else if (mret_commit) begin
                                mstatus[trap_pkg::MSTATUS_MIE]  <= mstatus[trap_pkg::MSTATUS_MPIE];
                                mstatus[trap_pkg::MSTATUS_MPIE] <= 1'b1;
                        end
                end
        end

        assign intr_req = mstatus[trap_pkg::MSTATUS_MIE] & mie[trap_pkg::MIE_MEIE] &
                          mip[trap_pkg::MIP_MEIP];

        // the master never sees a stretched access
        a_no_wait : assert property (
                @(posedge clk) disable iff (!clrn)
                (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
        );

endmodule

/* hw/intr_sync.sv */
module intr_sync (
        input  logic clk,
        input  logic clrn,
        input  logic intr,                              // async level, active high
        input  logic intr_ack,                          // arbiter took the interrupt
        output logic pending                            // latched request
);

        logic sync0;                                    // first sync flop
        logic sync1;                                    // second sync flop
        logic rise;                                     // synchronized rising edge

        assign rise = sync0 & ~sync1;                   // level went 0 -> 1

        always_ff @(posedge clk or negedge clrn) begin
                if (!clrn) begin
                        sync0 <= 1'b0;
                        sync1 <= 1'b0;
                end else begin
                        sync0 <= intr;                  // capture async input
                        sync1 <= sync0;                 // settle
                end
        end

        // new edge beats ack in the same cycle
        always_ff @(posedge clk or negedge clrn) begin
                if (!clrn) begin
                        pending <= 1'b0;
                end else if (rise) begin
                        pending <= 1'b1;                // set on edge
                end else if (intr_ack) begin
                        pending <= 1'b0;                // cleared once taken
                end
        end

        // an ack must always come from a request this block raised
        a_ack_needs_pending : assert property (
                @(posedge clk) disable iff (!clrn)
                intr_ack |-> pending
        );

endmodule

/* hw/pc_redirect.sv */
module pc_redirect (
        input  logic                clk,
        input  logic                clrn,
        input  trap_pkg::trap_req_t taken,            // trap entry this cycle
        input  logic                mret_commit,
        input  trap_pkg::xlen_t     mtvec,            // pre-edge vector base
        input  trap_pkg::xlen_t     mepc,             // pre-edge return pc
        output trap_pkg::redirect_t redirect
);

        logic            vld_q;                         // one-cycle redirect strobe
        trap_pkg::xlen_t tgt_q;                         // captured target
        trap_pkg::xlen_t tgt_nxt;                       // trap over mret

        assign tgt_nxt = taken.valid ? mtvec : mepc;

        always_ff @(posedge clk or negedge clrn) begin
                if (!clrn) begin
                        vld_q <= 1'b0;
                end else begin
                        vld_q <= taken.valid | mret_commit;     // high for exactly one cycle
                end
        end

        always_ff @(posedge clk) begin
                if (taken.valid | mret_commit) begin
                        tgt_q <= tgt_nxt;               // old csr value, before update lands
                end
        end

        assign redirect.valid  = vld_q;
        assign redirect.target = tgt_q;

endmodule

/* hw/trap_arbiter.sv */
module trap_arbiter (
        input  logic                clk,              // assertion clock only
        input  logic                clrn,
        input  trap_pkg::trap_req_t ex_trap,          // oldest source
        input  trap_pkg::trap_req_t id_trap,
        input  logic                id_valid,         // instr in id can carry an interrupt
        input  trap_pkg::xlen_t     id_pc,
        input  logic                intr_req,         // enabled and pending
        output trap_pkg::trap_req_t taken,            // the single winning request
        output logic                intr_ack,         // clears pending in intr_sync
        output trap_pkg::flush_t    flush
);

        logic intr_take;                                // interrupt wins this cycle

        assign intr_take = intr_req & id_valid & ~ex_trap.valid & ~id_trap.valid;
        assign intr_ack  = intr_take;

        // oldest stage wins, interrupt rides on the id instruction
        always_comb begin
                taken = '0;
                flush = '0;
                if (ex_trap.valid) begin
                        taken     = ex_trap;
                        flush.id  = 1'b1;               // younger instr behind it
                        flush.mem = 1'b1;               // faulting instr must not commit
                end else if (id_trap.valid) begin
                        taken    = id_trap;
                        flush.id = 1'b1;
                        flush.ex = 1'b1;                // bubble into ex
                end else if (intr_take) begin
                        taken.valid   = 1'b1;
                        taken.is_intr = 1'b1;
                        taken.cause   = trap_pkg::CAUSE_EXT_INTR;
                        taken.pc      = id_pc;          // resume at the interrupted instr
                        flush.id      = 1'b1;
                        flush.ex      = 1'b1;
                end
        end

        // ex and id patterns are exclusive, mem squash never pairs with ex bubble
        a_flush_onehot_src : assert property (
                @(posedge clk) disable iff (!clrn)
                !(flush.ex && flush.mem)
        );

endmodule

/* hw/trap_ctrl_top.sv */
module trap_ctrl_top (
        input  logic                clk,
        input  logic                clrn,
        input  logic                intr,             // external interrupt, async
        input  logic                id_valid,
        input  trap_pkg::xlen_t     id_pc,
        input  trap_pkg::trap_req_t id_trap,
        input  trap_pkg::trap_req_t ex_trap,
        input  logic                mret_commit,
        input  trap_pkg::apb_req_t  apb_req,
        output trap_pkg::apb_rsp_t  apb_rsp,
        output trap_pkg::flush_t    flush,
        output trap_pkg::redirect_t redirect
);

        logic                pending;                   // mip.meip source
        logic                intr_req;                  // enabled interrupt
        logic                intr_ack;                  // interrupt taken
        trap_pkg::trap_req_t taken;                     // winning request
        trap_pkg::xlen_t     mtvec;
        trap_pkg::xlen_t     mepc;

        intr_sync i_intr_sync (
                .clk      (clk),
                .clrn     (clrn),
                .intr     (intr),
                .intr_ack (intr_ack),
                .pending  (pending)
        );

        trap_arbiter i_trap_arbiter (
                .clk      (clk),
                .clrn     (clrn),
                .ex_trap  (ex_trap),
                .id_trap  (id_trap),
                .id_valid (id_valid),
                .id_pc    (id_pc),
                .intr_req (intr_req),
                .taken    (taken),
                .intr_ack (intr_ack),
                .flush    (flush)
        );

        csr_regs i_csr_regs (
                .clk         (clk),
                .clrn        (clrn),
                .apb_req     (apb_req),
                .apb_rsp     (apb_rsp),
                .pending     (pending),
                .taken       (taken),
                .mret_commit (mret_commit),
                .intr_req    (intr_req),
                .mtvec       (mtvec),
                .mepc        (mepc)
        );

        pc_redirect i_pc_redirect (
                .clk         (clk),
                .clrn        (clrn),
                .taken       (taken),
                .mret_commit (mret_commit),
                .mtvec       (mtvec),
                .mepc        (mepc),
                .redirect    (redirect)
        );

endmodule

/* hw/trap_pkg.sv */
package trap_pkg;

        localparam int XLEN       = 32;                 // machine word width
        localparam int CAUSE_W    = 4;                  // low cause code bits kept
        localparam int CSR_ADDR_W = 4;                  // apb word offset width

        typedef logic [XLEN-1:0]    xlen_t;             // one machine word
        typedef logic [CAUSE_W-1:0] cause_t;            // trap cause code

        // csr word offsets on the apb port
        localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS = 4'd0;
        localparam logic [CSR_ADDR_W-1:0] ADDR_MIE     = 4'd1;
        localparam logic [CSR_ADDR_W-1:0] ADDR_MIP     = 4'd2;
        localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC    = 4'd3;
        localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE  = 4'd4;
        localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC   = 4'd5;

        localparam int MSTATUS_MIE     = 3;             // global machine int enable
        localparam int MSTATUS_MPIE    = 7;             // previous mie
        localparam int MIE_MEIE        = 11;            // external int enable
        localparam int MIP_MEIP        = 11;            // external int pending
        localparam int MCAUSE_INTR_BIT = 31;            // interrupt flag in mcause

        localparam cause_t CAUSE_EXT_INTR = 4'd11;      // machine external interrupt
        localparam xlen_t  MTVEC_RESET    = 32'h0000_0100;

        typedef struct packed {
                logic   valid;                          // request present
                logic   is_intr;                        // interrupt, not exception
                cause_t cause;                          // low cause bits
                xlen_t  pc;                             // pc saved to mepc
        } trap_req_t;                                   // 38 bits

        typedef struct packed {
                logic id;                               // squash id stage
                logic ex;                               // squash ex stage
                logic mem;                              // squash mem stage
        } flush_t;

        typedef struct packed {
                logic  valid;                           // take the target this cycle
                xlen_t target;                          // next pc
        } redirect_t;                                   // 33 bits

        typedef struct packed {
                logic                  psel;
                logic                  penable;
                logic                  pwrite;
                logic [CSR_ADDR_W-1:0] paddr;           // word offset
                xlen_t                 pwdata;
        } apb_req_t;

        typedef struct packed {
                xlen_t prdata;
                logic  pready;
                logic  pslverr;
        } apb_rsp_t;

endpackage

/* run.sh */
#!/bin/sh
# build and run the trap controller testbench with verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_trap_ctrl -f files.f -o tb_trap_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_trap_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
    exit 1
fi
exit 0

/* tests/tb_trap_ctrl.sv */
module tb_trap_ctrl;

        localparam trap_pkg::xlen_t MTVEC_VAL  = 32'h0000_2000;  // vector base set by the test
        localparam int              WAIT_LIMIT = 32;             // cycles any wait may take

        typedef struct packed {
                trap_pkg::trap_req_t ex_trap;                   // stimulus
                trap_pkg::trap_req_t id_trap;
                logic                id_valid;
                trap_pkg::xlen_t     id_pc;
                trap_pkg::flush_t    exp_flush;                 // in the request cycle
                trap_pkg::redirect_t exp_redirect;              // one cycle later
                trap_pkg::xlen_t     exp_mepc;                  // read back over apb
                trap_pkg::xlen_t     exp_mcause;
        } trap_case_t;

        logic                clk = 1'b0;
        logic                clrn;
        logic                intr;
        logic                id_valid;
        trap_pkg::xlen_t     id_pc;
        trap_pkg::trap_req_t id_trap;
        trap_pkg::trap_req_t ex_trap;
        logic                mret_commit;
        trap_pkg::apb_req_t  apb_req;
        trap_pkg::apb_rsp_t  apb_rsp;
        trap_pkg::flush_t    flush;
        trap_pkg::redirect_t redirect;
        trap_case_t          cases [$];                 // trap table
        trap_pkg::xlen_t     irq_pc;                    // pc sitting in id when intr hits
        int                  errors   = 0;
        int                  timeouts = 0;

        trap_ctrl_top i_dut (.*);

        always #4 clk = ~clk;                           // 8 unit period

        task automatic check_word(input trap_pkg::xlen_t got, exp, input string what);
                if (got !== exp) begin
                        $display("Error %0t: %s got %h expected %h", $time, what, got, exp);
                        errors++;
                end
        endtask

        task automatic check_flush(input trap_pkg::flush_t got, exp, input string what);
                if (got !== exp) begin
                        $display("Error %0t: %s flush got %b expected %b", $time, what, got, exp);
                        errors++;
                end
        endtask

        // target only matters when a redirect is expected
        task automatic check_redirect(input trap_pkg::redirect_t got, exp, input string what);
                if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
                        $display("Error %0t: %s redirect got %b/%h expected %b/%h", $time, what,
                                 got.valid, got.target, exp.valid, exp.target);
                        errors++;
                end
        endtask

        function automatic trap_pkg::xlen_t rand_pc();
                return $urandom & 32'hffff_fffc;        // word aligned
        endfunction

        function automatic trap_pkg::trap_req_t exc_req(input trap_pkg::cause_t cause,
                                                        input trap_pkg::xlen_t pc);
                return {1'b1, 1'b0, cause, pc};         // valid synchronous exception
        endfunction

        task automatic add_case(input trap_pkg::trap_req_t ex, id, input logic idv,
                                input trap_pkg::xlen_t idpc, input trap_pkg::flush_t fl,
                                input logic rv, input trap_pkg::xlen_t epc, cause);
                cases.push_back({ex, id, idv, idpc, fl, rv, MTVEC_VAL, epc, cause});
        endtask

        task automatic build_cases();
                trap_pkg::xlen_t pc [6];
                foreach (pc[i]) begin
                        pc[i] = rand_pc();
                end
                // ex flushes id and mem while id and interrupt flush id and ex
                add_case(exc_req(4'd2, pc[0]), '0, 1'b1, pc[1], 3'b101, 1'b1, pc[0], 32'd2);
                add_case('0, exc_req(4'd3, pc[1]), 1'b1, pc[1], 3'b110, 1'b1, pc[1], 32'd3);
                add_case(exc_req(4'd5, pc[2]), exc_req(4'd8, pc[3]), 1'b1, pc[3],
                         3'b101, 1'b1, pc[2], 32'd5);   // older ex wins over id
                add_case('0, exc_req(4'd4, pc[4]), 1'b0, pc[4], 3'b110, 1'b1, pc[4], 32'd4);
                add_case(exc_req(4'd15, pc[5]), exc_req(4'd1, pc[4]), 1'b0, pc[4],
                         3'b101, 1'b1, pc[5], 32'd15);
                add_case('0, '0, 1'b1, pc[0], 3'b000, 1'b0, pc[5], 32'd15);  // idle cycle
        endtask

        // access phase is open, poll pready at the falling edge
        task automatic wait_ready();
                @(negedge clk);
                for (int n = 0; n < WAIT_LIMIT && !apb_rsp.pready; n++) begin
                        @(negedge clk);
                end
                if (!apb_rsp.pready) begin
                        $display("APB slave never raised pready within the timeout");
                        timeouts++;
                end
        endtask

        task automatic apb_write(input logic [trap_pkg::CSR_ADDR_W-1:0] addr,
                                 input trap_pkg::xlen_t data);
                @(posedge clk);
                apb_req <= {1'b1, 1'b0, 1'b1, addr, data};     // setup phase
                @(posedge clk);
                apb_req.penable <= 1'b1;                        // access phase
                wait_ready();
                @(posedge clk);                                 // csr takes the write here
                apb_req <= '0;
        endtask

        task automatic apb_read(input logic [trap_pkg::CSR_ADDR_W-1:0] addr,
                                output trap_pkg::xlen_t data, output logic err);
                @(posedge clk);
                apb_req <= {1'b1, 1'b0, 1'b0, addr, 32'h0};
                @(posedge clk);
                apb_req.penable <= 1'b1;
                wait_ready();
                data = apb_rsp.prdata;                          // comb in the access phase
                err  = apb_rsp.pslverr;
                @(posedge clk);
                apb_req <= '0;
        endtask

        task automatic expect_csr(input logic [trap_pkg::CSR_ADDR_W-1:0] addr,
                                  input trap_pkg::xlen_t exp, input string what);
                trap_pkg::xlen_t data;
                logic            err;
                apb_read(addr, data, err);
                check_word(data, exp, what);
                if (err !== 1'b0) begin
                        $display("Error %0t: %s pslverr on a mapped offset", $time, what);
                        errors++;
                end
        endtask

        task automatic run_trap_table();
                foreach (cases[i]) begin
                        @(posedge clk);
                        ex_trap  <= cases[i].ex_trap;
                        id_trap  <= cases[i].id_trap;
                        id_valid <= cases[i].id_valid;
                        id_pc    <= cases[i].id_pc;
                        @(negedge clk);
                        check_flush(flush, cases[i].exp_flush, $sformatf("case %0d", i));
                        @(posedge clk);
                        ex_trap  <= '0;                 // requests last one cycle
                        id_trap  <= '0;
                        id_valid <= 1'b0;
                        @(negedge clk);
                        check_redirect(redirect, cases[i].exp_redirect, $sformatf("case %0d", i));
                        expect_csr(trap_pkg::ADDR_MEPC, cases[i].exp_mepc,
                                   $sformatf("case %0d mepc", i));
                        expect_csr(trap_pkg::ADDR_MCAUSE, cases[i].exp_mcause,
                                   $sformatf("case %0d mcause", i));
                end
        endtask

        task automatic check_interrupt();
                logic seen;
                seen = 1'b0;
                apb_write(trap_pkg::ADDR_MSTATUS, 32'h0000_0008);       // mie on with mpie off
                irq_pc = rand_pc();
                @(posedge clk);
                intr     <= 1'b1;
                id_valid <= 1'b1;
                id_pc    <= irq_pc;
                for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
                        @(negedge clk);
                        seen = (flush != '0);           // first flush is the interrupt
                end
                if (seen) begin
                        check_flush(flush, 3'b110, "interrupt");
                end else begin
                        $display("enabled interrupt was not taken within the timeout");
                        timeouts++;
                end
                @(posedge clk);
                intr     <= 1'b0;
                id_valid <= 1'b0;
                @(negedge clk);
                check_redirect(redirect, {1'b1, MTVEC_VAL}, "interrupt");
                expect_csr(trap_pkg::ADDR_MCAUSE, 32'h8000_000b, "interrupt mcause");
                expect_csr(trap_pkg::ADDR_MEPC, irq_pc, "interrupt mepc");
                expect_csr(trap_pkg::ADDR_MSTATUS, 32'h0000_0080, "interrupt mstatus");
                expect_csr(trap_pkg::ADDR_MIP, 32'h0, "interrupt mip");
        endtask

        task automatic check_masked_interrupt();
                @(posedge clk);
                intr     <= 1'b1;                       // fresh edge while mstatus.mie is clear
                id_valid <= 1'b1;
                for (int n = 0; n < WAIT_LIMIT; n++) begin
                        @(negedge clk);
                        check_flush(flush, '0, "masked interrupt");
                end
                expect_csr(trap_pkg::ADDR_MIP, 32'h0000_0800, "masked mip");
                @(posedge clk);
                intr     <= 1'b0;
                id_valid <= 1'b0;
        endtask

        task automatic check_mret();
                @(posedge clk);
                mret_commit <= 1'b1;
                @(posedge clk);
                mret_commit <= 1'b0;
                @(negedge clk);
                check_redirect(redirect, {1'b1, irq_pc}, "mret");
                expect_csr(trap_pkg::ADDR_MSTATUS, 32'h0000_0088, "mret mstatus");
        endtask

        initial begin
                trap_pkg::xlen_t data;
                logic            err;
                clrn        = 1'b0;
                intr        = 1'b0;
                id_valid    = 1'b0;
                id_pc       = '0;
                id_trap     = '0;
                ex_trap     = '0;
                mret_commit = 1'b0;
                apb_req     = '0;
                void'($urandom(55260));
                build_cases();
                repeat (10) @(posedge clk);
                clrn <= 1'b1;
                for (int a = 0; a < 6; a++) begin      // only mtvec leaves reset non zero
                        expect_csr(4'(a), (4'(a) == trap_pkg::ADDR_MTVEC) ?
                                   trap_pkg::MTVEC_RESET : 32'h0, $sformatf("reset csr %0d", a));
                end
                apb_read(4'ha, data, err);
                if (err !== 1'b1) begin
                        $display("Error %0t: no pslverr on unmapped offset", $time);
                        errors++;
                end
                @(negedge clk);
                check_flush(flush, '0, "idle");
                apb_write(trap_pkg::ADDR_MTVEC, MTVEC_VAL);
                apb_write(trap_pkg::ADDR_MIE, 32'h0000_0800);
                apb_write(trap_pkg::ADDR_MSTATUS, 32'h0000_0088);
                apb_write(trap_pkg::ADDR_MIP, 32'hffff_ffff);       // read only
                expect_csr(trap_pkg::ADDR_MTVEC, MTVEC_VAL, "mtvec");
                expect_csr(trap_pkg::ADDR_MIE, 32'h0000_0800, "mie");
                expect_csr(trap_pkg::ADDR_MSTATUS, 32'h0000_0088, "mstatus");
                expect_csr(trap_pkg::ADDR_MIP, 32'h0, "mip");
                run_trap_table();
                check_interrupt();
                check_masked_interrupt();
                check_mret();
                $display("errors %0d timeouts %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule
